/* ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// operand and result width
`define EX_XLEN 32

// destination register index width
`define EX_REG_BITS 5

// merge FIFO entry count, pointer width follows from it
`define EX_FIFO_DEPTH 8

`endif

/* ex_pkg.sv */
`include "ex_macros.svh"

package ex_pkg;

    // 4-bit operation code seen by each execute lane
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5, // signed compare
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_BEQ = 4'd8,
        ALU_BNE = 4'd9
    } alu_op_t;

    // one executed instruction on its way to memory/writeback
    typedef struct packed {
        logic                      valid;       // single-cycle strobe
        logic [`EX_XLEN-1:0]       npc;
        logic [`EX_XLEN-1:0]       alu_result;
        logic [`EX_REG_BITS-1:0]   dest_reg;
        logic                      take_branch;
        logic                      lane;        // issuing lane, 0 or 1
    } ex_packet_t;

endpackage

/* ex_alu_lane.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_alu_lane import ex_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue,
    input  alu_op_t                   op,
    input  logic [`EX_XLEN-1:0]       pc,
    input  logic [`EX_XLEN-1:0]       rs1,
    input  logic [`EX_XLEN-1:0]       rs2,
    input  logic [`EX_REG_BITS-1:0]   dest,
    input  logic                      lane_id,
    output ex_packet_t                packet
);

    logic [`EX_XLEN-1:0]     result;
    logic                    take;
    logic                    slt_lt;
    logic [4:0]              shamt;
    logic [`EX_XLEN-1:0]     npc;

    // registered packet
    logic                    valid_q;
    logic [`EX_XLEN-1:0]     npc_q;
    logic [`EX_XLEN-1:0]     result_q;
    logic [`EX_REG_BITS-1:0] dest_q;
    logic                    take_q;
    logic                    lane_q;

    assign shamt  = rs2[4:0];                       // low five bits only
    assign slt_lt = $signed(rs1) < $signed(rs2);

    always_comb begin
        result = '0;
        take   = 1'b0;
        case (op)
            ALU_ADD: result = rs1 + rs2;
            ALU_SUB: result = rs1 - rs2;
            ALU_AND: result = rs1 & rs2;
            ALU_OR:  result = rs1 | rs2;
            ALU_XOR: result = rs1 ^ rs2;
            ALU_SLT: result = {{(`EX_XLEN-1){1'b0}}, slt_lt};
            ALU_SLL: result = rs1 << shamt;
            ALU_SRL: result = rs1 >> shamt;
            ALU_BEQ: take = (rs1 == rs2);           // result stays zero
            ALU_BNE: take = (rs1 != rs2);
            default: begin
                result = '0;
                take   = 1'b0;
            end
        endcase
    end

    // branch target is pc relative, offset carried in rs2
    assign npc = take ? (pc + rs2) : (pc + `EX_XLEN'(4));

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue;                       // strobe, one cycle only
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            npc_q    <= npc;
            result_q <= result;
            dest_q   <= dest;
            take_q   <= take;
            lane_q   <= lane_id;
        end
    end

    assign packet = '{
        valid:       valid_q,
        npc:         npc_q,
        alu_result:  result_q,
        dest_reg:    dest_q,
        take_branch: take_q,
        lane:        lane_q
    };

endmodule

/* ex_merge_fifo.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_merge_fifo import ex_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  ex_packet_t in_old,     // lane 0, older when both arrive
    input  ex_packet_t in_young,   // lane 1
    output ex_packet_t out_packet
);

    localparam int CNT_W = $clog2(`EX_FIFO_DEPTH) + 1;

    ex_packet_t mem      [`EX_FIFO_DEPTH];
    ex_packet_t next_mem [`EX_FIFO_DEPTH];

    logic [CNT_W-1:0] count;       // number of stored entries
    logic [CNT_W-1:0] next_count;
    logic [CNT_W-1:0] base;        // first free slot after the head leaves
    logic [CNT_W-1:0] sum;

    logic       empty;
    logic       any_in;
    logic       both_in;
    ex_packet_t first_in;

    // packets to be written this cycle, a goes before the young input
    logic       store_a;
    logic       store_b;
    ex_packet_t pkt_a;

    assign empty    = (count == '0);
    assign any_in   = in_old.valid | in_young.valid;
    assign both_in  = in_old.valid & in_young.valid;
    assign first_in = in_old.valid ? in_old : in_young;

    // head, or the oldest arriving packet when nothing is stored
    always_comb begin
        if (!empty) begin
            out_packet = mem[0];
        end else if (any_in) begin
            out_packet = first_in;
        end else begin
            out_packet = '0;
        end
    end

    always_comb begin
        if (empty) begin
            // first arrival bypasses, only a second one is kept
            store_a = both_in;
            store_b = 1'b0;
            pkt_a   = in_young;
            base    = '0;
        end else begin
            store_a = any_in;
            store_b = both_in;
            pkt_a   = first_in;
            base    = count - CNT_W'(1);
        end
    end

    assign sum = base + CNT_W'(store_a) + CNT_W'(store_b);

    // anything beyond the last slot is dropped
    assign next_count = (sum > CNT_W'(`EX_FIFO_DEPTH)) ? CNT_W'(`EX_FIFO_DEPTH) : sum;

    always_comb begin
        for (int i = 0; i < `EX_FIFO_DEPTH; i++) begin
            next_mem[i] = mem[i];
        end

        if (!empty) begin
            for (int i = 0; i < `EX_FIFO_DEPTH - 1; i++) begin
                next_mem[i] = mem[i + 1];           // shift down past the head
            end
        end

        for (int i = 0; i < `EX_FIFO_DEPTH; i++) begin
            if (store_a && (i == int'(base))) begin
                next_mem[i] = pkt_a;
            end else if (store_b && (i == int'(base) + 1)) begin
                next_mem[i] = in_young;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `EX_FIFO_DEPTH; i++) begin
            mem[i] <= next_mem[i];
        end
    end

endmodule

/* ex_dual_lane.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_dual_lane import ex_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      lane0_issue,
    input  alu_op_t                   lane0_op,
    input  logic [`EX_XLEN-1:0]       lane0_pc,
    input  logic [`EX_XLEN-1:0]       lane0_rs1,
    input  logic [`EX_XLEN-1:0]       lane0_rs2,
    input  logic [`EX_REG_BITS-1:0]   lane0_dest,

    input  logic                      lane1_issue,
    input  alu_op_t                   lane1_op,
    input  logic [`EX_XLEN-1:0]       lane1_pc,
    input  logic [`EX_XLEN-1:0]       lane1_rs1,
    input  logic [`EX_XLEN-1:0]       lane1_rs2,
    input  logic [`EX_REG_BITS-1:0]   lane1_dest,

    output logic                      retire_valid,
    output logic [`EX_XLEN-1:0]       retire_npc,
    output logic [`EX_XLEN-1:0]       retire_result,
    output logic [`EX_REG_BITS-1:0]   retire_dest,
    output logic                      retire_take_branch,
    output logic                      retire_lane
);

    ex_packet_t lane0_packet;
    ex_packet_t lane1_packet;
    ex_packet_t retire_packet;

    // lane 0 always carries the older instruction
    ex_alu_lane u_lane0 (
        .clock   (clock),
        .reset   (reset),
        .issue   (lane0_issue),
        .op      (lane0_op),
        .pc      (lane0_pc),
        .rs1     (lane0_rs1),
        .rs2     (lane0_rs2),
        .dest    (lane0_dest),
        .lane_id (1'b0),
        .packet  (lane0_packet)
    );

    ex_alu_lane u_lane1 (
        .clock   (clock),
        .reset   (reset),
        .issue   (lane1_issue),
        .op      (lane1_op),
        .pc      (lane1_pc),
        .rs1     (lane1_rs1),
        .rs2     (lane1_rs2),
        .dest    (lane1_dest),
        .lane_id (1'b1),
        .packet  (lane1_packet)
    );

    ex_merge_fifo u_merge (
        .clock      (clock),
        .reset      (reset),
        .in_old     (lane0_packet),
        .in_young   (lane1_packet),
        .out_packet (retire_packet)
    );

    assign retire_valid       = retire_packet.valid;
    assign retire_npc         = retire_packet.npc;
    assign retire_result      = retire_packet.alu_result;
    assign retire_dest        = retire_packet.dest_reg;
    assign retire_take_branch = retire_packet.take_branch;
    assign retire_lane        = retire_packet.lane;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

endmodule

/* tb_ex_dual_lane.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module tb_ex_dual_lane import ex_pkg::*; ();

    localparam int MAX_OCC     = `EX_FIFO_DEPTH - 1;     // outstanding packets allowed
    localparam int DRAIN_LIMIT = 4 * `EX_FIFO_DEPTH + 8;

    logic                    clock;
    logic                    reset;
    logic                    lane0_issue;
    alu_op_t                 lane0_op;
    logic [`EX_XLEN-1:0]     lane0_pc;
    logic [`EX_XLEN-1:0]     lane0_rs1;
    logic [`EX_XLEN-1:0]     lane0_rs2;
    logic [`EX_REG_BITS-1:0] lane0_dest;
    logic                    lane1_issue;
    alu_op_t                 lane1_op;
    logic [`EX_XLEN-1:0]     lane1_pc;
    logic [`EX_XLEN-1:0]     lane1_rs1;
    logic [`EX_XLEN-1:0]     lane1_rs2;
    logic [`EX_REG_BITS-1:0] lane1_dest;
    logic                    retire_valid;
    logic [`EX_XLEN-1:0]     retire_npc;
    logic [`EX_XLEN-1:0]     retire_result;
    logic [`EX_REG_BITS-1:0] retire_dest;
    logic                    retire_take_branch;
    logic                    retire_lane;

    integer     seed = 32'hedb7;
    int         cycle;
    ex_packet_t exp_pkt[$];        // expected retire stream, issue order
    int         exp_cycle[$];      // required retire cycle, -1 when latency is free
    ex_packet_t exp_head;
    int         exp_due;

    tb_clock_gen u_clock_gen (.clock(clock));

    ex_dual_lane u_ex_dual_lane (.*);

    always @(posedge clock) cycle <= cycle + 1;

    task automatic stop_with_failure(input string why);
        $display("ERRORS FOUND");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %0t ns: %s got %h, expected %h", $time, what, actual, expected);
            stop_with_failure("retire stream differs from the reference model");
        end
    endtask

    function automatic logic [`EX_XLEN-1:0] corner_value(input logic [2:0] sel);
        case (sel)
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h0000_0001;
            3'd2:    return 32'h7fff_ffff;     // largest positive
            3'd3:    return 32'h8000_0000;     // most negative
            3'd4:    return 32'hffff_ffff;
            default: return 32'h0000_003f;     // shift amount above 31
        endcase
    endfunction

    // expected packet straight from the lane rules
    function automatic ex_packet_t model_packet(input alu_op_t op,
            input logic [`EX_XLEN-1:0] pc, input logic [`EX_XLEN-1:0] rs1,
            input logic [`EX_XLEN-1:0] rs2, input logic [`EX_REG_BITS-1:0] dest,
            input logic lane);
        ex_packet_t p;
        p.valid       = 1'b1;
        p.alu_result  = '0;
        p.take_branch = 1'b0;
        case (op)
            ALU_ADD: p.alu_result = rs1 + rs2;
            ALU_SUB: p.alu_result = rs1 - rs2;
            ALU_AND: p.alu_result = rs1 & rs2;
            ALU_OR:  p.alu_result = rs1 | rs2;
            ALU_XOR: p.alu_result = rs1 ^ rs2;
            ALU_SLT: p.alu_result = ($signed(rs1) < $signed(rs2)) ? `EX_XLEN'(1) : '0;
            ALU_SLL: p.alu_result = rs1 << rs2[4:0];
            ALU_SRL: p.alu_result = rs1 >> rs2[4:0];
            ALU_BEQ: p.take_branch = (rs1 == rs2);
            ALU_BNE: p.take_branch = (rs1 != rs2);
            default: p.alu_result = '0;
        endcase
        p.npc      = p.take_branch ? pc + rs2 : pc + `EX_XLEN'(4);
        p.dest_reg = dest;
        p.lane     = lane;
        return p;
    endfunction

    task automatic random_operation(output alu_op_t op, output logic [`EX_XLEN-1:0] pc,
            output logic [`EX_XLEN-1:0] rs1, output logic [`EX_XLEN-1:0] rs2,
            output logic [`EX_REG_BITS-1:0] dest);
        logic [31:0] r;
        r    = $random(seed);
        op   = alu_op_t'(4'(r % 32'd10));
        r    = $random(seed);
        rs1  = (r[1:0] == 2'd0) ? corner_value(r[4:2]) : $random(seed);
        r    = $random(seed);
        rs2  = (r[1:0] == 2'd0) ? corner_value(r[4:2]) : $random(seed);
        if ((op == ALU_BEQ || op == ALU_BNE) && r[5]) begin
            rs2 = rs1;                          // equal operands half the time
        end
        r    = $random(seed);
        pc   = {r[31:2], 2'b00};
        r    = $random(seed);
        dest = r[4:0];
    endtask

    // one issue slot, trimmed so the FIFO never overfills
    task automatic issue_cycle(input logic [1:0] want, output logic [1:0] mode);
        alu_op_t                 op;
        logic [`EX_XLEN-1:0]     pc;
        logic [`EX_XLEN-1:0]     rs1;
        logic [`EX_XLEN-1:0]     rs2;
        logic [`EX_REG_BITS-1:0] dest;
        int                      due;
        @(posedge clock);
        #1;
        mode = want;
        if (mode == 2'b11 && exp_pkt.size() + 2 > MAX_OCC) mode = 2'b01;
        if (mode != 2'b00 && exp_pkt.size() + 1 > MAX_OCC) mode = 2'b00;
        due = (exp_pkt.size() == 0) ? cycle + 1 : -1;   // bypass, oldest packet only
        lane0_issue = mode[0];
        lane1_issue = mode[1];
        if (mode[0]) begin
            random_operation(op, pc, rs1, rs2, dest);
            lane0_op   = op;
            lane0_pc   = pc;
            lane0_rs1  = rs1;
            lane0_rs2  = rs2;
            lane0_dest = dest;
            exp_pkt.push_back(model_packet(op, pc, rs1, rs2, dest, 1'b0));
            exp_cycle.push_back(due);
            due = -1;
        end
        if (mode[1]) begin
            random_operation(op, pc, rs1, rs2, dest);
            lane1_op   = op;
            lane1_pc   = pc;
            lane1_rs1  = rs1;
            lane1_rs2  = rs2;
            lane1_dest = dest;
            exp_pkt.push_back(model_packet(op, pc, rs1, rs2, dest, 1'b1));
            exp_cycle.push_back(due);
        end
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while (exp_pkt.size() != 0 && waited < limit) begin
            @(posedge clock);
            waited++;
        end
        if (exp_pkt.size() != 0) begin
            stop_with_failure("timed out waiting for issued packets to retire");
        end
    endtask

    // retire outputs are settled by the falling edge
    always @(negedge clock) begin
        if (cycle > 0) begin
            if (reset || retire_valid !== 1'b1) begin
                compare_value("retire_valid", 32'(retire_valid), 32'd0);
            end else if (exp_pkt.size() == 0) begin
                stop_with_failure("a packet retired although nothing was outstanding");
            end else begin
                exp_head = exp_pkt.pop_front();
                exp_due  = exp_cycle.pop_front();
                compare_value("retire_npc", retire_npc, exp_head.npc);
                compare_value("retire_result", retire_result, exp_head.alu_result);
                compare_value("retire_dest", 32'(retire_dest), 32'(exp_head.dest_reg));
                compare_value("retire_take_branch", 32'(retire_take_branch),
                              32'(exp_head.take_branch));
                compare_value("retire_lane", 32'(retire_lane), 32'(exp_head.lane));
                if (exp_due >= 0) compare_value("retire cycle", 32'(cycle), 32'(exp_due));
            end
        end
    end

    initial begin
        logic [1:0]  got;
        logic [31:0] r;
        reset       = 1'b1;
        lane0_issue = 1'b0;
        lane0_op    = ALU_ADD;
        lane0_pc    = '0;
        lane0_rs1   = '0;
        lane0_rs2   = '0;
        lane0_dest  = '0;
        lane1_issue = 1'b0;
        lane1_op    = ALU_ADD;
        lane1_pc    = '0;
        lane1_rs1   = '0;
        lane1_rs2   = '0;
        lane1_dest  = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (6) issue_cycle(2'b00, got);          // quiet after reset

        repeat (24) begin                            // single issue into an empty FIFO
            r = $random(seed);
            issue_cycle(r[0] ? 2'b10 : 2'b01, got);
            issue_cycle(2'b00, got);
            drain(DRAIN_LIMIT);
        end

        repeat (12) begin                            // short dual-issue bursts
            r = $random(seed);
            for (int i = 0; i <= int'(r[1:0]); i++) issue_cycle(2'b11, got);
            issue_cycle(2'b00, got);
            drain(DRAIN_LIMIT);
        end

        repeat (400) begin
            r = $random(seed);
            issue_cycle(r[1:0], got);
        end
        issue_cycle(2'b00, got);
        drain(DRAIN_LIMIT);

        // fill up to one below depth, then let it drain
        repeat (4) begin
            for (int i = 0; i < 4 * `EX_FIFO_DEPTH; i++) begin
                issue_cycle(2'b11, got);
                if (got != 2'b11) break;
            end
            issue_cycle(2'b00, got);
            drain(DRAIN_LIMIT);
        end

        repeat (4) issue_cycle(2'b00, got);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
ex_pkg.sv
ex_alu_lane.sv
ex_merge_fifo.sv
ex_dual_lane.sv
tb_clock_gen.sv
tb_ex_dual_lane.sv

/* Makefile */
# Verilator build and run for the dual-lane execute block

VERILATOR  ?= verilator
TOP        ?= tb_ex_dual_lane
LINT_TOP   ?= ex_dual_lane
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the simulation exits non-zero on $fatal
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
